// File: hw/exe_settings.svh
`ifndef EXE_SETTINGS_SVH
`define EXE_SETTINGS_SVH

// data path width
`define XLEN 32

// register file address width
`define REG_ADDR_W 5

`endif

// File: hw/rvIsaPkg.sv
package rvIsaPkg;

    `include "exe_settings.svh"

    // integer ALU functions
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_EQ   = 4'd10,   // compare only, for BEQ/BNE
        ALU_LTU  = 4'd11    // compare only, for BLTU/BGEU
    } aluFnT;

    // M extension ops, same order as funct3
    typedef enum logic [2:0] {
        MUL_MUL    = 3'd0,
        MUL_MULH   = 3'd1,
        MUL_MULHSU = 3'd2,
        MUL_MULHU  = 3'd3,
        MUL_DIV    = 3'd4,
        MUL_DIVU   = 3'd5,
        MUL_REM    = 3'd6,
        MUL_REMU   = 3'd7
    } mulOpT;

    typedef enum logic [1:0] {
        BR_NONE   = 2'd0,
        BR_BRANCH = 2'd1,
        BR_JAL    = 2'd2,
        BR_JALR   = 2'd3
    } brKindT;

    // code 4 is held for load data, which comes from the memory stage
    typedef enum logic [2:0] {
        WB_ALU    = 3'd0,
        WB_LINK   = 3'd1,
        WB_MULDIV = 3'd2,
        WB_LUI    = 3'd3,
        WB_AUIPC  = 3'd5
    } wbSelT;

endpackage

// File: hw/exePipePkg.sv
package exePipePkg;

    `include "exe_settings.svh"

    import rvIsaPkg::*;

    // one issued instruction, as it enters stage 5
    typedef struct packed {
        logic                   valid;
        logic                   regWrite;
        logic [`REG_ADDR_W-1:0] rd;
        aluFnT                  aluFn;
        mulOpT                  mulOp;
        brKindT                 brKind;
        wbSelT                  wbSel;
        logic                   brInvert;  // EQ -> NE, LT -> GE
        logic [`XLEN-1:0]       opA;
        logic [`XLEN-1:0]       opB;       // I immediate for JALR
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       bImm;
        logic [`XLEN-1:0]       jImm;
        logic [`XLEN-1:0]       uImm;
    } issueT;

    // state handed from stage 5 to stage 6
    typedef struct packed {
        logic                   valid;
        logic                   regWrite;
        logic [`REG_ADDR_W-1:0] rd;
        wbSelT                  wbSel;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       uImm;
        logic [`XLEN-1:0]       aluRes;
        logic [`XLEN-1:0]       mulRes;
    } stage6T;

    // register file write port
    typedef struct packed {
        logic                   valid;
        logic                   regWrite;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       wbData;
    } wbT;

    // fetch redirect
    typedef struct packed {
        logic                   taken;
        logic [`XLEN-1:0]       target;
    } redirT;

endpackage

// File: hw/intAlu.sv
`timescale 1ns/1ns
`include "exe_settings.svh"

module intAlu import rvIsaPkg::*;
(
    input  aluFnT            aluFn,
    input  logic [`XLEN-1:0] opA,
    input  logic [`XLEN-1:0] opB,
    output logic [`XLEN-1:0] aluRes,
    output logic             cmpTrue
);

    logic [$clog2(`XLEN)-1:0] shAmt;
    logic                     isEq;
    logic                     isLt;
    logic                     isLtu;

    assign shAmt = opB[$clog2(`XLEN)-1:0];  // only low bits count
    assign isEq  = (opA == opB);
    assign isLt  = ($signed(opA) < $signed(opB));
    assign isLtu = (opA < opB);

    always_comb
    begin
        aluRes  = '0;
        cmpTrue = 1'b0;
        case (aluFn)
            ALU_ADD:
                aluRes = opA + opB;
            ALU_SUB:
                aluRes = opA - opB;
            ALU_AND:
                aluRes = opA & opB;
            ALU_OR:
                aluRes = opA | opB;
            ALU_XOR:
                aluRes = opA ^ opB;
            ALU_SLL:
                aluRes = opA << shAmt;
            ALU_SRL:
                aluRes = opA >> shAmt;
            ALU_SRA:
                aluRes = $unsigned($signed(opA) >>> shAmt);  // keeps sign bit
            ALU_SLT:
            begin
                aluRes  = {{(`XLEN-1){1'b0}}, isLt};
                cmpTrue = isLt;  // BLT/BGE
            end
            ALU_SLTU:
            begin
                aluRes  = {{(`XLEN-1){1'b0}}, isLtu};
                cmpTrue = isLtu;
            end
            // branch-only compares leave aluRes at zero
            ALU_EQ:
                cmpTrue = isEq;
            ALU_LTU:
                cmpTrue = isLtu;
            default:
            begin
                aluRes  = '0;
                cmpTrue = 1'b0;
            end
        endcase
    end

endmodule

// File: hw/branchUnit.sv
`timescale 1ns/1ns
`include "exe_settings.svh"

module branchUnit import rvIsaPkg::*, exePipePkg::*;
(
    input  logic             valid,
    input  brKindT           brKind,
    input  logic             brInvert,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] opA,
    input  logic [`XLEN-1:0] opB,
    input  logic [`XLEN-1:0] bImm,
    input  logic [`XLEN-1:0] jImm,
    input  logic             cmpTrue,
    output redirT            redir
);

    logic             takeRaw;
    logic [`XLEN-1:0] jalrSum;
    logic [`XLEN-1:0] target;

    assign jalrSum = opA + opB;  // rs1 + I immediate

    always_comb
    begin
        takeRaw = 1'b0;
        target  = '0;
        case (brKind)
            BR_BRANCH:
            begin
                takeRaw = cmpTrue ^ brInvert;
                target  = pc + bImm;
            end
            BR_JAL:
            begin
                takeRaw = 1'b1;
                target  = pc + jImm;
            end
            BR_JALR:
            begin
                takeRaw = 1'b1;
                target  = {jalrSum[`XLEN-1:1], 1'b0};  // spec clears bit 0
            end
            default:
            begin
                takeRaw = 1'b0;
                target  = '0;
            end
        endcase
    end

    assign redir.taken  = valid & takeRaw;  // bubbles never redirect
    assign redir.target = target;

    // pc and immediates from decode must keep targets on halfword boundaries
    always_comb
    begin
        assert final (!redir.taken || !redir.target[0])
            else $error("branchUnit: odd redirect target %h", redir.target);
    end

endmodule

// File: hw/mulUnit.sv
`timescale 1ns/1ns
`include "exe_settings.svh"

module mulUnit import rvIsaPkg::*;
(
    input  mulOpT            mulOp,
    input  logic [`XLEN-1:0] opA,
    input  logic [`XLEN-1:0] opB,
    output logic [`XLEN-1:0] mulRes
);

    logic                      aSign;
    logic                      bSign;
    logic signed [`XLEN:0]     aExt;
    logic signed [`XLEN:0]     bExt;
    logic signed [2*`XLEN+1:0] prod;
    logic                      divZero;
    logic                      divOvf;
    logic [`XLEN-1:0]          divisorS;
    logic [`XLEN-1:0]          divisorU;
    logic [`XLEN-1:0]          quoS;
    logic [`XLEN-1:0]          remS;
    logic [`XLEN-1:0]          quoU;
    logic [`XLEN-1:0]          remU;

    // one signed multiplier for all four variants
    assign aSign = ((mulOp == MUL_MULH) || (mulOp == MUL_MULHSU)) & opA[`XLEN-1];
    assign bSign = (mulOp == MUL_MULH) & opB[`XLEN-1];
    assign aExt  = {aSign, opA};
    assign bExt  = {bSign, opB};
    assign prod  = aExt * bExt;

    assign divZero = (opB == '0);
    assign divOvf  = (opA == {1'b1, {(`XLEN-1){1'b0}}}) && (opB == '1);

    // dividing by one in the overflow case gives dividend and zero remainder
    assign divisorS = (divZero || divOvf) ? `XLEN'(1) : opB;
    assign divisorU = divZero ? `XLEN'(1) : opB;

    assign quoS = $unsigned($signed(opA) / $signed(divisorS));
    assign remS = $unsigned($signed(opA) % $signed(divisorS));
    assign quoU = opA / divisorU;
    assign remU = opA % divisorU;

    always_comb
    begin
        case (mulOp)
            MUL_MUL:                        mulRes = prod[`XLEN-1:0];
            MUL_MULH, MUL_MULHSU, MUL_MULHU: mulRes = prod[2*`XLEN-1:`XLEN];
            MUL_DIV:                        mulRes = divZero ? '1 : quoS;
            MUL_DIVU:                       mulRes = divZero ? '1 : quoU;
            MUL_REM:                        mulRes = divZero ? opA : remS;
            MUL_REMU:                       mulRes = divZero ? opA : remU;
            default:                        mulRes = '0;
        endcase
    end

    // stage-5 register should always hold a defined op
    always_comb
    begin
        assert final (!$isunknown(mulOp))
            else $error("mulUnit: mulOp is unknown");
    end

endmodule

// File: hw/wbSelect.sv
`timescale 1ns/1ns
`include "exe_settings.svh"

module wbSelect import rvIsaPkg::*, exePipePkg::*;
(
    input  logic             clk,
    input  logic             nrst,
    input  issueT            issue5,
    input  logic [`XLEN-1:0] aluRes,
    input  logic [`XLEN-1:0] mulRes,
    output wbT               wb
);

    stage6T           s6;
    logic [`XLEN-1:0] wbData;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            s6 <= '0;
        else
        begin
            s6.valid    <= issue5.valid;
            s6.regWrite <= issue5.regWrite;
            s6.rd       <= issue5.rd;
            s6.wbSel    <= issue5.wbSel;
            s6.pc       <= issue5.pc;
            s6.uImm     <= issue5.uImm;
            s6.aluRes   <= aluRes;
            s6.mulRes   <= mulRes;
        end
    end

    // every source here uses the stage-6 copy
    always_comb
    begin
        case (s6.wbSel)
            WB_ALU:    wbData = s6.aluRes;
            WB_LINK:   wbData = s6.pc + `XLEN'(4);  // return address
            WB_MULDIV: wbData = s6.mulRes;
            WB_LUI:    wbData = s6.uImm;
            WB_AUIPC:  wbData = s6.pc + s6.uImm;
            default:   wbData = '0;
        endcase
    end

    assign wb.valid    = s6.valid;
    assign wb.regWrite = s6.regWrite;
    assign wb.rd       = s6.rd;
    assign wb.wbData   = wbData;

    // load writeback is not handled in this stage
    assert property (@(posedge clk) disable iff (!nrst)
        s6.valid |-> (s6.wbSel inside {WB_ALU, WB_LINK, WB_MULDIV, WB_LUI, WB_AUIPC}))
        else $error("wbSelect: illegal wbSel %0d", s6.wbSel);

endmodule

// File: hw/exeStage.sv
`timescale 1ns/1ns
`include "exe_settings.svh"

module exeStage import exePipePkg::*;
(
    input  logic  clk,
    input  logic  nrst,
    input  issueT issue,
    output redirT redir,
    output wbT    wb
);

    issueT            issue5;   // stage-5 register
    logic [`XLEN-1:0] aluRes;
    logic [`XLEN-1:0] mulRes;
    logic             cmpTrue;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            issue5 <= '0;
        else
            issue5 <= issue;  // new item every cycle, no stall
    end

    intAlu intAlu_i (
        .aluFn   (issue5.aluFn),
        .opA     (issue5.opA),
        .opB     (issue5.opB),
        .aluRes  (aluRes),
        .cmpTrue (cmpTrue)
    );

    mulUnit mulUnit_i (
        .mulOp  (issue5.mulOp),
        .opA    (issue5.opA),
        .opB    (issue5.opB),
        .mulRes (mulRes)
    );

    // redirect leaves one cycle after issue
    branchUnit branchUnit_i (
        .valid    (issue5.valid),
        .brKind   (issue5.brKind),
        .brInvert (issue5.brInvert),
        .pc       (issue5.pc),
        .opA      (issue5.opA),
        .opB      (issue5.opB),
        .bImm     (issue5.bImm),
        .jImm     (issue5.jImm),
        .cmpTrue  (cmpTrue),
        .redir    (redir)
    );

    wbSelect wbSelect_i (
        .clk    (clk),
        .nrst   (nrst),
        .issue5 (issue5),
        .aluRes (aluRes),
        .mulRes (mulRes),
        .wb     (wb)
    );

endmodule

// File: tb/exeStageTests.svh
function automatic logic lessSigned(logic [`XLEN-1:0] a, logic [`XLEN-1:0] b);
    return (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : (a < b);  // sign bits decide first
endfunction

function automatic logic cmpRef(aluFnT fn, logic [`XLEN-1:0] a, logic [`XLEN-1:0] b);
    case (fn)
        ALU_EQ:            return a == b;
        ALU_SLT:           return lessSigned(a, b);
        ALU_SLTU, ALU_LTU: return a < b;
        default:           return 1'b0;
    endcase
endfunction

function automatic logic [`XLEN-1:0] aluRef(aluFnT fn, logic [`XLEN-1:0] a,
                                            logic [`XLEN-1:0] b);
    logic [`XLEN-1:0] r;
    int               sh;
    sh = int'(b[4:0]);
    r  = '0;  // compare-only codes write zero
    case (fn)
        ALU_ADD:  r = a + b;
        ALU_SUB:  r = a + ~b + `XLEN'(1);
        ALU_AND:  r = a & b;
        ALU_OR:   r = a | b;
        ALU_XOR:  r = a ^ b;
        ALU_SLL:  r = a << sh;
        ALU_SRL:  r = a >> sh;
        ALU_SRA:
        begin
            r = a;
            repeat (sh) r = {r[`XLEN-1], r[`XLEN-1:1]};
        end
        ALU_SLT:  r = {{(`XLEN-1){1'b0}}, lessSigned(a, b)};
        ALU_SLTU: r = {{(`XLEN-1){1'b0}}, a < b};
        default:  r = '0;
    endcase
    return r;
endfunction

function automatic logic [`XLEN-1:0] mulRef(mulOpT op, logic [`XLEN-1:0] a,
                                            logic [`XLEN-1:0] b);
    logic [2*`XLEN-1:0]      pUU;
    logic [2*`XLEN-1:0]      pSS;
    logic [2*`XLEN-1:0]      pSU;
    logic                    negMin;
    logic signed [`XLEN-1:0] sq;
    logic signed [`XLEN-1:0] sr;
    logic [`XLEN-1:0]        uq;
    logic [`XLEN-1:0]        ur;
    pUU    = {`XLEN'(0), a} * {`XLEN'(0), b};
    pSS    = {{`XLEN{a[`XLEN-1]}}, a} * {{`XLEN{b[`XLEN-1]}}, b};
    pSU    = {{`XLEN{a[`XLEN-1]}}, a} * {`XLEN'(0), b};
    negMin = (a == {1'b1, {(`XLEN-1){1'b0}}}) && (b == '1);
    sq = '1;  // divide by zero results
    sr = a;
    uq = '1;
    ur = a;
    if (b != '0)
    begin
        uq = a / b;
        ur = a % b;
        if (negMin)
        begin
            sq = a;
            sr = '0;
        end
        else
        begin
            sq = $signed(a) / $signed(b);
            sr = $signed(a) % $signed(b);
        end
    end
    case (op)
        MUL_MUL:    return pUU[`XLEN-1:0];
        MUL_MULH:   return pSS[2*`XLEN-1:`XLEN];
        MUL_MULHSU: return pSU[2*`XLEN-1:`XLEN];
        MUL_MULHU:  return pUU[2*`XLEN-1:`XLEN];
        MUL_DIV:    return sq;
        MUL_DIVU:   return uq;
        MUL_REM:    return sr;
        default:    return ur;
    endcase
endfunction

function automatic logic takenRef(issueT it);
    if (!it.valid)
        return 1'b0;
    case (it.brKind)
        BR_BRANCH:       return cmpRef(it.aluFn, it.opA, it.opB) != it.brInvert;
        BR_JAL, BR_JALR: return 1'b1;
        default:         return 1'b0;
    endcase
endfunction

function automatic logic [`XLEN-1:0] targetRef(issueT it);
    case (it.brKind)
        BR_BRANCH: return it.pc + it.bImm;
        BR_JAL:    return it.pc + it.jImm;
        default:   return (it.opA + it.opB) & {{(`XLEN-1){1'b1}}, 1'b0};
    endcase
endfunction

function automatic logic [`XLEN-1:0] wbDataRef(issueT it);
    case (it.wbSel)
        WB_ALU:    return aluRef(it.aluFn, it.opA, it.opB);
        WB_LINK:   return it.pc + `XLEN'(4);
        WB_MULDIV: return mulRef(it.mulOp, it.opA, it.opB);
        WB_LUI:    return it.uImm;
        WB_AUIPC:  return it.pc + it.uImm;
        default:   return '0;
    endcase
endfunction

function automatic issueT aluItem(aluFnT fn, logic [`XLEN-1:0] a, logic [`XLEN-1:0] b);
    issueT it;
    it          = '0;
    it.valid    = 1'b1;
    it.regWrite = 1'b1;
    it.rd       = `REG_ADDR_W'(7);
    it.aluFn    = fn;
    it.wbSel    = WB_ALU;
    it.opA      = a;
    it.opB      = b;
    return it;
endfunction

task automatic checkRedir(issueT it);
    checkEq("redir.taken", `XLEN'(takenRef(it)), `XLEN'(redir.taken));
    if (takenRef(it))
        checkEq("redir.target", targetRef(it), redir.target);
endtask

task automatic checkWb(issueT it);
    checkEq("wb.valid", `XLEN'(it.valid), `XLEN'(wb.valid));
    if (it.valid)
    begin
        checkEq("wb.regWrite", `XLEN'(it.regWrite), `XLEN'(wb.regWrite));
        checkEq("wb.rd", `XLEN'(it.rd), `XLEN'(wb.rd));
        if (it.regWrite)
            checkEq("wb.wbData", wbDataRef(it), wb.wbData);
    end
endtask

// one item followed by bubbles, redir after 1 cycle and wb after 2
task automatic runOne(issueT it);
    @(posedge clk);
    issue <= it;
    @(posedge clk);
    issue <= '0;
    @(negedge clk);
    checkRedir(it);
    @(negedge clk);
    checkWb(it);
endtask

task automatic makeRandom(output issueT it);
    logic [31:0] r;
    r  = $random(seed);
    it = aluItem(aluFnT'(4'(r[7:0] % 8'd10)), $random(seed), $random(seed));
    it.rd   = r[12:8];
    it.mulOp = mulOpT'(r[15:13]);
    it.pc   = {$random(seed)} & 32'hffff_fffc;
    it.bImm = {$random(seed)} & 32'hffff_fffe;
    it.jImm = {$random(seed)} & 32'hffff_fffe;
    it.uImm = {$random(seed)} & 32'hffff_f000;
    it.brInvert = r[22];
    case (r[18:16])
        3'd2:    it.wbSel = WB_MULDIV;
        3'd3:
        begin
            it.brKind   = BR_BRANCH;
            it.regWrite = 1'b0;
            it.aluFn    = (r[24:23] == 2'd0) ? ALU_EQ : ((r[24:23] == 2'd1) ? ALU_SLT : ALU_LTU);
        end
        3'd4:
        begin
            it.brKind = BR_JAL;
            it.wbSel  = WB_LINK;
        end
        3'd5:
        begin
            it.brKind = BR_JALR;
            it.wbSel  = WB_LINK;
        end
        3'd6:    it.wbSel = WB_LUI;
        3'd7:    it.wbSel = WB_AUIPC;
        default: it.wbSel = WB_ALU;
    endcase
    it.valid = r[25] | r[26];  // roughly one idle in four
endtask

task automatic aluTests();
    logic [`XLEN-1:0] corner [numCorners];
    logic [31:0]      r;
    corner = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0023};
    for (int f = 0; f < 10; f++)
        for (int i = 0; i < numCorners; i++)
            runOne(aluItem(aluFnT'(f), corner[i], corner[numCorners-1-i]));
    repeat (numAluRandom)
    begin
        r = $random(seed);
        runOne(aluItem(aluFnT'(4'(r % 10)), $random(seed), $random(seed)));
    end
endtask

task automatic mulTests();
    logic [`XLEN-1:0] ma [numMulPairs];
    logic [`XLEN-1:0] mb [numMulPairs];
    issueT            it;
    // signs mixed, overflow, divide by zero, then one random pair
    ma = '{32'd7, 32'hffff_fff9, 32'd7, 32'h8000_0000, 32'd5, 32'hffff_fffb, '1, 32'd0};
    mb = '{32'd3, 32'd3, 32'hffff_fffd, 32'hffff_ffff, 32'd0, 32'd0, '1, 32'd0};
    ma[numMulPairs-1] = $random(seed);
    mb[numMulPairs-1] = $random(seed);
    for (int op = 0; op < 8; op++)
        for (int i = 0; i < numMulPairs; i++)
        begin
            it       = aluItem(ALU_ADD, ma[i], mb[i]);
            it.mulOp = mulOpT'(op);
            it.wbSel = WB_MULDIV;
            runOne(it);
        end
endtask

task automatic branchTests();
    logic [`XLEN-1:0] pa [3];
    logic [`XLEN-1:0] pb [3];
    issueT            it;
    pa = '{32'd5, 32'hffff_ffff, 32'd1};
    pb = '{32'd5, 32'd1, 32'hffff_ffff};
    for (int c = 0; c < 3; c++)
        for (int inv = 0; inv < 2; inv++)
            for (int p = 0; p < 3; p++)
            begin
                it = aluItem((c == 0) ? ALU_EQ : ((c == 1) ? ALU_SLT : ALU_LTU), pa[p], pb[p]);
                it.brKind   = BR_BRANCH;
                it.brInvert = inv[0];
                it.regWrite = 1'b0;
                it.pc       = 32'h0000_1000;
                it.bImm     = 32'hffff_fff0;
                runOne(it);
            end
    it        = aluItem(ALU_ADD, '0, '0);
    it.brKind = BR_JAL;
    it.wbSel  = WB_LINK;
    it.pc     = 32'h0000_2000;
    it.jImm   = 32'h0000_0800;
    runOne(it);
    it.brKind = BR_JALR;  // odd sum, bit 0 dropped
    it.opA    = 32'h0000_3001;
    it.opB    = 32'h0000_0010;
    runOne(it);
    it.opA    = 32'h0000_3000;
    it.opB    = 32'hffff_ffff;
    runOne(it);
    it.valid  = 1'b0;
    runOne(it);
endtask

task automatic upperTests();
    issueT it;
    for (int i = 0; i < numUpper; i++)
    begin
        it       = aluItem(ALU_ADD, $random(seed), $random(seed));
        it.wbSel = (i % 2 == 0) ? WB_LUI : WB_AUIPC;
        it.pc    = {$random(seed)} & 32'hffff_fffc;
        it.uImm  = {$random(seed)} & 32'hffff_f000;
        runOne(it);
    end
endtask

// back to back, each wb checked two cycles after its issue
task automatic streamTest();
    issueT sent [$];
    issueT it;
    for (int i = 0; i < numStream + 2; i++)
    begin
        @(posedge clk);
        it = '0;
        if (i < numStream)
            makeRandom(it);
        issue <= it;
        sent.push_back(it);
        @(negedge clk);
        if (i >= 1)
            checkRedir(sent[i-1]);
        if (i >= 2)
            checkWb(sent[i-2]);
    end
    @(posedge clk);
    issue <= '0;
endtask

// File: tb/exeStageTb.sv
`timescale 1ns/1ns
`include "exe_settings.svh"

module exeStageTb
    import rvIsaPkg::*, exePipePkg::*;
();

    localparam int numCorners   = 6;
    localparam int numAluRandom = 40;
    localparam int numMulPairs  = 8;
    localparam int numBranch    = 22;   // 18 conditional plus 4 jumps
    localparam int numUpper     = 6;
    localparam int numStream    = 50;
    localparam int singleItems  = 10 * numCorners + numAluRandom + 8 * numMulPairs
                                  + numBranch + numUpper;
    // each single item takes three cycles, the stream one per item
    localparam int cycleLimit   = 2 * (10 + 3 * singleItems + numStream + 8);

    logic   clk;
    logic   nrst;
    issueT  issue;
    redirT  redir;
    wbT     wb;
    integer seed;
    int     cycles = 0;

    exeStage exeStage_i (
        .clk   (clk),
        .nrst  (nrst),
        .issue (issue),
        .redir (redir),
        .wb    (wb)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit)
        begin
            $display("timeout: tests did not finish within %0d cycles", cycleLimit);
            $display("Done: errors found");
            $fatal(1, "run stopped by timeout");
        end
    end

    task automatic checkEq(input string name, input logic [`XLEN-1:0] exp,
                           input logic [`XLEN-1:0] act);
        if (act !== exp)
        begin
            $display("** Error @ %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("Done: errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    `include "exeStageTests.svh"

    initial
    begin
        seed  = 32'h339b9ef9;
        nrst  = 1'b0;
        issue = '0;
        repeat (10) @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);
        checkEq("wb.valid", `XLEN'(1'b0), `XLEN'(wb.valid));  // nothing issued yet
        checkEq("redir.taken", `XLEN'(1'b0), `XLEN'(redir.taken));
        aluTests();
        mulTests();
        branchTests();
        upperTests();
        streamTest();
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: project.f
+incdir+hw
+incdir+tb
hw/rvIsaPkg.sv
hw/exePipePkg.sv
hw/intAlu.sv
hw/branchUnit.sv
hw/mulUnit.sv
hw/wbSelect.sv
hw/exeStage.sv
tb/exeStageTb.sv

// File: Makefile
SIM        = verilator
TOP        = exeStageTb
DUT_TOP    = exeStage
FILELIST   = project.f
OBJDIR     = obj_dir
LOG        = sim.log
FLAGS      = --binary --timing --assert --timescale 1ns/1ns -j 0
LINT_FLAGS = --lint-only -Wall --timing --timescale 1ns/1ns

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
